// ==== Makefile ====
# Verilator build and run of the PCIe function bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_pcie_func_bridge
FILELIST  ?= pcie_func_bridge.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/pcie_bridge_params.svh ====
// Width and depth macros shared by the PCIe function bridge and its testbench
// Include before using the package types or sizing the packet buffers
`ifndef PCIE_BRIDGE_PARAMS_SVH
`define PCIE_BRIDGE_PARAMS_SVH

// Stream beat
`define PB_DATA_W 32
`define PB_KEEP_W 4

// Bank address widths, 128 words for control and 512 for data
`define PB_CTRL_ADDR_W 7
`define PB_DATA_ADDR_W 9

`endif

// ==== common/pcie_bridge_pkg.sv ====
// Types shared by the bridge, the ping-pong buffers and the router
`default_nettype none

`include "pcie_bridge_params.svh"

package pcie_bridge_pkg;

  typedef logic [`PB_DATA_W-1:0] word_t;
  typedef logic [`PB_KEEP_W-1:0] keep_t;

  // One flag per ping-pong bank
  typedef logic [1:0] bank_t;

  // Bit 0 of the PCIe function number
  typedef enum logic {
    FUNC_CONTROL = 1'b0,
    FUNC_DATA    = 1'b1
  } func_id_e;

endpackage

`default_nettype wire

// ==== hdl/pcie_func_bridge.sv ====
// Top level of the PCIe function bridge, router plus ping-pong buffers per function
// i_func_sel stands in for bit 0 of the endpoint's function number
`timescale 1ns/1ps
`default_nettype none

`include "pcie_bridge_params.svh"

module pcie_func_bridge (
  input  wire                            clk,
  input  wire                            i_rst_n,
  input  wire pcie_bridge_pkg::func_id_e i_func_sel,
  input  wire pcie_bridge_pkg::word_t    i_rx_tdata,
  input  wire pcie_bridge_pkg::keep_t    i_rx_tkeep,
  input  wire                            i_rx_tlast,
  input  wire                            i_rx_tvalid,
  output logic                           o_rx_tready,
  output pcie_bridge_pkg::word_t         o_tx_tdata,
  output pcie_bridge_pkg::keep_t         o_tx_tkeep,
  output logic                           o_tx_tlast,
  output logic                           o_tx_tvalid,
  input  wire                            i_tx_tready,
  output pcie_bridge_pkg::word_t         o_ctrl_in_tdata,
  output pcie_bridge_pkg::keep_t         o_ctrl_in_tkeep,
  output logic                           o_ctrl_in_tlast,
  output logic                           o_ctrl_in_tvalid,
  input  wire                            i_ctrl_in_tready,
  output pcie_bridge_pkg::word_t         o_data_in_tdata,
  output pcie_bridge_pkg::keep_t         o_data_in_tkeep,
  output logic                           o_data_in_tlast,
  output logic                           o_data_in_tvalid,
  input  wire                            i_data_in_tready,
  input  wire pcie_bridge_pkg::word_t    i_ctrl_out_tdata,
  input  wire pcie_bridge_pkg::keep_t    i_ctrl_out_tkeep,
  input  wire                            i_ctrl_out_tlast,
  input  wire                            i_ctrl_out_tvalid,
  output logic                           o_ctrl_out_tready,
  input  wire pcie_bridge_pkg::word_t    i_data_out_tdata,
  input  wire pcie_bridge_pkg::keep_t    i_data_out_tkeep,
  input  wire                            i_data_out_tlast,
  input  wire                            i_data_out_tvalid,
  output logic                           o_data_out_tready
);

  import pcie_bridge_pkg::*;

  // Router to ingress buffers
  word_t ctrl_rx_tdata;
  keep_t ctrl_rx_tkeep;
  logic  ctrl_rx_tlast;
  logic  ctrl_rx_tvalid;
  logic  ctrl_rx_tready;
  word_t data_rx_tdata;
  keep_t data_rx_tkeep;
  logic  data_rx_tlast;
  logic  data_rx_tvalid;
  logic  data_rx_tready;

  // Egress buffers to router
  word_t ctrl_tx_tdata;
  keep_t ctrl_tx_tkeep;
  logic  ctrl_tx_tlast;
  logic  ctrl_tx_tvalid;
  logic  ctrl_tx_tready;
  word_t data_tx_tdata;
  keep_t data_tx_tkeep;
  logic  data_tx_tlast;
  logic  data_tx_tvalid;
  logic  data_tx_tready;

  pcie_func_router u_router (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_func_sel       (i_func_sel),
    .i_rx_tdata       (i_rx_tdata),
    .i_rx_tkeep       (i_rx_tkeep),
    .i_rx_tlast       (i_rx_tlast),
    .i_rx_tvalid      (i_rx_tvalid),
    .o_rx_tready      (o_rx_tready),
    .o_ctrl_rx_tdata  (ctrl_rx_tdata),
    .o_ctrl_rx_tkeep  (ctrl_rx_tkeep),
    .o_ctrl_rx_tlast  (ctrl_rx_tlast),
    .o_ctrl_rx_tvalid (ctrl_rx_tvalid),
    .i_ctrl_rx_tready (ctrl_rx_tready),
    .o_data_rx_tdata  (data_rx_tdata),
    .o_data_rx_tkeep  (data_rx_tkeep),
    .o_data_rx_tlast  (data_rx_tlast),
    .o_data_rx_tvalid (data_rx_tvalid),
    .i_data_rx_tready (data_rx_tready),
    .i_ctrl_tx_tdata  (ctrl_tx_tdata),
    .i_ctrl_tx_tkeep  (ctrl_tx_tkeep),
    .i_ctrl_tx_tlast  (ctrl_tx_tlast),
    .i_ctrl_tx_tvalid (ctrl_tx_tvalid),
    .o_ctrl_tx_tready (ctrl_tx_tready),
    .i_data_tx_tdata  (data_tx_tdata),
    .i_data_tx_tkeep  (data_tx_tkeep),
    .i_data_tx_tlast  (data_tx_tlast),
    .i_data_tx_tvalid (data_tx_tvalid),
    .o_data_tx_tready (data_tx_tready),
    .o_tx_tdata       (o_tx_tdata),
    .o_tx_tkeep       (o_tx_tkeep),
    .o_tx_tlast       (o_tx_tlast),
    .o_tx_tvalid      (o_tx_tvalid),
    .i_tx_tready      (i_tx_tready)
  );

  pp_packet_buffer #(.ADDR_W(`PB_CTRL_ADDR_W)) u_ctrl_ingress (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_s_tdata  (ctrl_rx_tdata),
    .i_s_tkeep  (ctrl_rx_tkeep),
    .i_s_tlast  (ctrl_rx_tlast),
    .i_s_tvalid (ctrl_rx_tvalid),
    .o_s_tready (ctrl_rx_tready),
    .o_m_tdata  (o_ctrl_in_tdata),
    .o_m_tkeep  (o_ctrl_in_tkeep),
    .o_m_tlast  (o_ctrl_in_tlast),
    .o_m_tvalid (o_ctrl_in_tvalid),
    .i_m_tready (i_ctrl_in_tready)
  );

  pp_packet_buffer #(.ADDR_W(`PB_DATA_ADDR_W)) u_data_ingress (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_s_tdata  (data_rx_tdata),
    .i_s_tkeep  (data_rx_tkeep),
    .i_s_tlast  (data_rx_tlast),
    .i_s_tvalid (data_rx_tvalid),
    .o_s_tready (data_rx_tready),
    .o_m_tdata  (o_data_in_tdata),
    .o_m_tkeep  (o_data_in_tkeep),
    .o_m_tlast  (o_data_in_tlast),
    .o_m_tvalid (o_data_in_tvalid),
    .i_m_tready (i_data_in_tready)
  );

  pp_packet_buffer #(.ADDR_W(`PB_CTRL_ADDR_W)) u_ctrl_egress (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_s_tdata  (i_ctrl_out_tdata),
    .i_s_tkeep  (i_ctrl_out_tkeep),
    .i_s_tlast  (i_ctrl_out_tlast),
    .i_s_tvalid (i_ctrl_out_tvalid),
    .o_s_tready (o_ctrl_out_tready),
    .o_m_tdata  (ctrl_tx_tdata),
    .o_m_tkeep  (ctrl_tx_tkeep),
    .o_m_tlast  (ctrl_tx_tlast),
    .o_m_tvalid (ctrl_tx_tvalid),
    .i_m_tready (ctrl_tx_tready)
  );

  pp_packet_buffer #(.ADDR_W(`PB_DATA_ADDR_W)) u_data_egress (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_s_tdata  (i_data_out_tdata),
    .i_s_tkeep  (i_data_out_tkeep),
    .i_s_tlast  (i_data_out_tlast),
    .i_s_tvalid (i_data_out_tvalid),
    .o_s_tready (o_data_out_tready),
    .o_m_tdata  (data_tx_tdata),
    .o_m_tkeep  (data_tx_tkeep),
    .o_m_tlast  (data_tx_tlast),
    .o_m_tvalid (data_tx_tvalid),
    .i_m_tready (data_tx_tready)
  );

endmodule

`default_nettype wire

// ==== hdl/pcie_func_router.sv ====
// Steers the endpoint rx stream to one function and the tx stream from one function
// The function is latched on a packet's first beat and held to its last
`timescale 1ns/1ps
`default_nettype none

module pcie_func_router (
  input  wire                            clk,
  input  wire                            i_rst_n,
  input  wire pcie_bridge_pkg::func_id_e i_func_sel,
  input  wire pcie_bridge_pkg::word_t    i_rx_tdata,
  input  wire pcie_bridge_pkg::keep_t    i_rx_tkeep,
  input  wire                            i_rx_tlast,
  input  wire                            i_rx_tvalid,
  output logic                           o_rx_tready,
  output pcie_bridge_pkg::word_t         o_ctrl_rx_tdata,
  output pcie_bridge_pkg::keep_t         o_ctrl_rx_tkeep,
  output logic                           o_ctrl_rx_tlast,
  output logic                           o_ctrl_rx_tvalid,
  input  wire                            i_ctrl_rx_tready,
  output pcie_bridge_pkg::word_t         o_data_rx_tdata,
  output pcie_bridge_pkg::keep_t         o_data_rx_tkeep,
  output logic                           o_data_rx_tlast,
  output logic                           o_data_rx_tvalid,
  input  wire                            i_data_rx_tready,
  input  wire pcie_bridge_pkg::word_t    i_ctrl_tx_tdata,
  input  wire pcie_bridge_pkg::keep_t    i_ctrl_tx_tkeep,
  input  wire                            i_ctrl_tx_tlast,
  input  wire                            i_ctrl_tx_tvalid,
  output logic                           o_ctrl_tx_tready,
  input  wire pcie_bridge_pkg::word_t    i_data_tx_tdata,
  input  wire pcie_bridge_pkg::keep_t    i_data_tx_tkeep,
  input  wire                            i_data_tx_tlast,
  input  wire                            i_data_tx_tvalid,
  output logic                           o_data_tx_tready,
  output pcie_bridge_pkg::word_t         o_tx_tdata,
  output pcie_bridge_pkg::keep_t         o_tx_tkeep,
  output logic                           o_tx_tlast,
  output logic                           o_tx_tvalid,
  input  wire                            i_tx_tready
);

  import pcie_bridge_pkg::*;

  logic     rx_busy;
  logic     tx_busy;
  func_id_e rx_func;
  func_id_e tx_func;
  func_id_e rx_sel;
  func_id_e tx_sel;
  logic     rx_ctrl;
  logic     tx_ctrl;

  // Mid-packet the latched function wins over the live select
  assign rx_sel  = rx_busy ? rx_func : i_func_sel;
  assign tx_sel  = tx_busy ? tx_func : i_func_sel;
  assign rx_ctrl = (rx_sel == FUNC_CONTROL);
  assign tx_ctrl = (tx_sel == FUNC_CONTROL);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rx_busy <= 1'b0;
      tx_busy <= 1'b0;
      rx_func <= FUNC_CONTROL;
      tx_func <= FUNC_CONTROL;
    end else begin
      if (i_rx_tvalid && o_rx_tready) begin
        rx_busy <= ~i_rx_tlast;
        rx_func <= rx_sel;
      end
      if (o_tx_tvalid && i_tx_tready) begin
        tx_busy <= ~o_tx_tlast;
        tx_func <= tx_sel;
      end
    end
  end

  // Payload fans out, only valid picks the function
  assign o_ctrl_rx_tdata  = i_rx_tdata;
  assign o_ctrl_rx_tkeep  = i_rx_tkeep;
  assign o_ctrl_rx_tlast  = i_rx_tlast;
  assign o_ctrl_rx_tvalid = i_rx_tvalid & rx_ctrl;
  assign o_data_rx_tdata  = i_rx_tdata;
  assign o_data_rx_tkeep  = i_rx_tkeep;
  assign o_data_rx_tlast  = i_rx_tlast;
  assign o_data_rx_tvalid = i_rx_tvalid & ~rx_ctrl;
  assign o_rx_tready      = rx_ctrl ? i_ctrl_rx_tready : i_data_rx_tready;

  assign o_tx_tdata       = tx_ctrl ? i_ctrl_tx_tdata  : i_data_tx_tdata;
  assign o_tx_tkeep       = tx_ctrl ? i_ctrl_tx_tkeep  : i_data_tx_tkeep;
  assign o_tx_tlast       = tx_ctrl ? i_ctrl_tx_tlast  : i_data_tx_tlast;
  assign o_tx_tvalid      = tx_ctrl ? i_ctrl_tx_tvalid : i_data_tx_tvalid;
  assign o_ctrl_tx_tready = i_tx_tready & tx_ctrl;
  assign o_data_tx_tready = i_tx_tready & ~tx_ctrl;

endmodule

`default_nettype wire

// ==== pcie_func_bridge.f ====
+incdir+common
common/pcie_bridge_pkg.sv
pp_buffer/ppfifo.sv
pp_buffer/axis_to_ppfifo.sv
pp_buffer/ppfifo_to_axis.sv
pp_buffer/pp_packet_buffer.sv
hdl/pcie_func_router.sv
hdl/pcie_func_bridge.sv
verif/tb_pcie_func_bridge.sv

// ==== pp_buffer/axis_to_ppfifo.sv ====
// Writes an AXI stream into ping-pong banks, one packet or one full bank at a time
`timescale 1ns/1ps
`default_nettype none

module axis_to_ppfifo #(
  parameter int ADDR_W = 7
) (
  input  wire                         clk,
  input  wire                         i_rst_n,
  input  wire pcie_bridge_pkg::word_t i_axis_tdata,
  input  wire pcie_bridge_pkg::keep_t i_axis_tkeep,
  input  wire                         i_axis_tlast,
  input  wire                         i_axis_tvalid,
  output logic                        o_axis_tready,
  input  wire pcie_bridge_pkg::bank_t i_pp_ready,
  output pcie_bridge_pkg::bank_t      o_pp_activate,
  output logic                        o_pp_stb,
  output pcie_bridge_pkg::word_t      o_pp_data,
  output pcie_bridge_pkg::keep_t      o_pp_keep
);

  localparam int BANK_SIZE = 2 ** ADDR_W;

  logic            next_bank;
  logic [ADDR_W:0] count;
  logic            beat;
  logic            release_bank;

  // Stream ready only while a bank is owned
  assign o_axis_tready = |o_pp_activate;
  assign beat          = i_axis_tvalid & o_axis_tready;
  assign release_bank  = beat & (i_axis_tlast | (count == (ADDR_W+1)'(BANK_SIZE - 1)));

  assign o_pp_stb  = beat;
  assign o_pp_data = i_axis_tdata;
  assign o_pp_keep = i_axis_tkeep;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pp_activate <= '0;
      next_bank     <= 1'b0;
      count         <= '0;
    end else if (o_pp_activate == '0) begin
      // Banks are taken in strict alternation
      if (i_pp_ready[next_bank]) begin
        o_pp_activate[next_bank] <= 1'b1;
        count                    <= '0;
      end
    end else if (beat) begin
      count <= count + 1'b1;
      if (release_bank) begin
        o_pp_activate <= '0;
        next_bank     <= ~next_bank;
      end
    end
  end

endmodule

`default_nettype wire

// ==== pp_buffer/pp_packet_buffer.sv ====
// One buffered stream direction, writer into a ping-pong FIFO and reader back out
// Holds up to two packets in flight
`timescale 1ns/1ps
`default_nettype none

module pp_packet_buffer #(
  parameter int ADDR_W = 7
) (
  input  wire                         clk,
  input  wire                         i_rst_n,
  input  wire pcie_bridge_pkg::word_t i_s_tdata,
  input  wire pcie_bridge_pkg::keep_t i_s_tkeep,
  input  wire                         i_s_tlast,
  input  wire                         i_s_tvalid,
  output logic                        o_s_tready,
  output pcie_bridge_pkg::word_t      o_m_tdata,
  output pcie_bridge_pkg::keep_t      o_m_tkeep,
  output logic                        o_m_tlast,
  output logic                        o_m_tvalid,
  input  wire                         i_m_tready
);

  import pcie_bridge_pkg::*;

  bank_t           wr_ready;
  bank_t           wr_activate;
  logic            wr_stb;
  word_t           wr_data;
  keep_t           wr_keep;
  logic            rd_ready;
  logic            rd_activate;
  logic            rd_stb;
  logic [ADDR_W:0] rd_count;
  word_t           rd_data;
  keep_t           rd_keep;

  axis_to_ppfifo #(.ADDR_W(ADDR_W)) u_writer (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_axis_tdata  (i_s_tdata),
    .i_axis_tkeep  (i_s_tkeep),
    .i_axis_tlast  (i_s_tlast),
    .i_axis_tvalid (i_s_tvalid),
    .o_axis_tready (o_s_tready),
    .i_pp_ready    (wr_ready),
    .o_pp_activate (wr_activate),
    .o_pp_stb      (wr_stb),
    .o_pp_data     (wr_data),
    .o_pp_keep     (wr_keep)
  );

  ppfifo #(.ADDR_W(ADDR_W)) u_fifo (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .o_wr_ready    (wr_ready),
    .i_wr_activate (wr_activate),
    .i_wr_stb      (wr_stb),
    .i_wr_data     (wr_data),
    .i_wr_keep     (wr_keep),
    .o_rd_ready    (rd_ready),
    .i_rd_activate (rd_activate),
    .i_rd_stb      (rd_stb),
    .o_rd_count    (rd_count),
    .o_rd_data     (rd_data),
    .o_rd_keep     (rd_keep)
  );

  ppfifo_to_axis #(.ADDR_W(ADDR_W)) u_reader (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_pp_ready    (rd_ready),
    .o_pp_activate (rd_activate),
    .i_pp_count    (rd_count),
    .o_pp_stb      (rd_stb),
    .i_pp_data     (rd_data),
    .i_pp_keep     (rd_keep),
    .o_axis_tdata  (o_m_tdata),
    .o_axis_tkeep  (o_m_tkeep),
    .o_axis_tlast  (o_m_tlast),
    .o_axis_tvalid (o_m_tvalid),
    .i_axis_tready (i_m_tready)
  );

endmodule

`default_nettype wire

// ==== pp_buffer/ppfifo.sv ====
// Two-bank ping-pong FIFO, a writer fills one bank while a reader drains the other
// Banks go to the reader in the order the writer released them
`timescale 1ns/1ps
`default_nettype none

module ppfifo #(
  parameter int ADDR_W = 7
) (
  input  wire                         clk,
  input  wire                         i_rst_n,
  output pcie_bridge_pkg::bank_t      o_wr_ready,
  input  wire pcie_bridge_pkg::bank_t i_wr_activate,
  input  wire                         i_wr_stb,
  input  wire pcie_bridge_pkg::word_t i_wr_data,
  input  wire pcie_bridge_pkg::keep_t i_wr_keep,
  output logic                        o_rd_ready,
  input  wire                         i_rd_activate,
  input  wire                         i_rd_stb,
  output logic [ADDR_W:0]             o_rd_count,
  output pcie_bridge_pkg::word_t      o_rd_data,
  output pcie_bridge_pkg::keep_t      o_rd_keep
);

  import pcie_bridge_pkg::*;

  localparam int DEPTH = 2 ** ADDR_W;

  word_t             mem_data [2][DEPTH];
  keep_t             mem_keep [2][DEPTH];

  bank_t             filled;
  bank_t             wr_act_q;
  logic [ADDR_W:0]   wr_count [2];
  logic              wr_bank;
  logic              rd_bank;
  logic              rd_act_q;
  logic [ADDR_W-1:0] rd_ptr;
  logic              rd_release;

  // The writer owns at most one bank at a time
  assign wr_bank    = i_wr_activate[1];
  assign rd_release = rd_act_q & ~i_rd_activate;

  always_ff @(posedge clk) begin
    if (i_wr_stb) begin
      mem_data[wr_bank][wr_count[wr_bank][ADDR_W-1:0]] <= i_wr_data;
      mem_keep[wr_bank][wr_count[wr_bank][ADDR_W-1:0]] <= i_wr_keep;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      filled   <= '0;
      wr_act_q <= '0;
      wr_count <= '{default: '0};
      rd_bank  <= 1'b0;
      rd_act_q <= 1'b0;
      rd_ptr   <= '0;
    end else begin
      wr_act_q <= i_wr_activate;
      rd_act_q <= i_rd_activate;
      for (int b = 0; b < 2; b++) begin
        // Falling activate hands the bank over
        if (wr_act_q[b] && !i_wr_activate[b]) begin
          filled[b] <= 1'b1;
        end else if (rd_release && rd_bank == 1'(b)) begin
          filled[b]   <= 1'b0;
          wr_count[b] <= '0;
        end
        if (i_wr_stb && wr_bank == 1'(b)) begin
          wr_count[b] <= wr_count[b] + 1'b1;
        end
      end
      if (rd_release) begin
        rd_bank <= ~rd_bank;
        rd_ptr  <= '0;
      end else if (i_rd_stb) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // A bank still held or just released is not offered again
  assign o_wr_ready = ~filled & ~wr_act_q & ~i_wr_activate;
  assign o_rd_ready = filled[rd_bank] & ~rd_act_q;
  assign o_rd_count = wr_count[rd_bank];

  // Fall-through read at the pointer
  assign o_rd_data  = mem_data[rd_bank][rd_ptr];
  assign o_rd_keep  = mem_keep[rd_bank][rd_ptr];

endmodule

`default_nettype wire

// ==== pp_buffer/ppfifo_to_axis.sv ====
// Reads filled ping-pong banks out as an AXI stream, last on each bank's final word
`timescale 1ns/1ps
`default_nettype none

module ppfifo_to_axis #(
  parameter int ADDR_W = 7
) (
  input  wire                         clk,
  input  wire                         i_rst_n,
  input  wire                         i_pp_ready,
  output logic                        o_pp_activate,
  input  wire [ADDR_W:0]              i_pp_count,
  output logic                        o_pp_stb,
  input  wire pcie_bridge_pkg::word_t i_pp_data,
  input  wire pcie_bridge_pkg::keep_t i_pp_keep,
  output pcie_bridge_pkg::word_t      o_axis_tdata,
  output pcie_bridge_pkg::keep_t      o_axis_tkeep,
  output logic                        o_axis_tlast,
  output logic                        o_axis_tvalid,
  input  wire                         i_axis_tready
);

  logic [ADDR_W:0] size;
  logic [ADDR_W:0] index;
  logic            beat;

  assign beat     = o_axis_tvalid & i_axis_tready;
  assign o_pp_stb = beat;

  assign o_axis_tdata = i_pp_data;
  assign o_axis_tkeep = i_pp_keep;
  assign o_axis_tlast = (index == size - 1'b1);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pp_activate <= 1'b0;
      o_axis_tvalid <= 1'b0;
      size          <= '0;
      index         <= '0;
    end else if (!o_pp_activate) begin
      if (i_pp_ready) begin
        o_pp_activate <= 1'b1;
        size          <= i_pp_count;
        index         <= '0;
      end
    end else if (!o_axis_tvalid) begin
      // First word is at the read pointer one cycle after activation
      o_axis_tvalid <= 1'b1;
    end else if (beat) begin
      index <= index + 1'b1;
      if (o_axis_tlast) begin
        o_axis_tvalid <= 1'b0;
        o_pp_activate <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_pcie_func_bridge.sv ====
// Testbench for the PCIe function bridge, drives rx and the user egress streams
// Scoreboards per output stream, checked beat by beat with immediate assertions
`timescale 1ns/1ps
`default_nettype none

`include "pcie_bridge_params.svh"

module tb_pcie_func_bridge;

  import pcie_bridge_pkg::*;

  localparam int LAST_BIT = `PB_DATA_W + `PB_KEEP_W;
  localparam int TIMEOUT  = 2000;
  localparam logic [31:0] SEED = 32'he1093cb7;

  // Expected beat is {last, keep, data}
  typedef logic [LAST_BIT:0] beat_t;

  logic     clk = 1'b0;
  logic     i_rst_n;
  func_id_e i_func_sel;
  word_t    i_rx_tdata;
  keep_t    i_rx_tkeep;
  logic     i_rx_tlast;
  logic     i_rx_tvalid;
  logic     o_rx_tready;
  word_t    o_tx_tdata;
  keep_t    o_tx_tkeep;
  logic     o_tx_tlast;
  logic     o_tx_tvalid;
  logic     i_tx_tready;
  word_t    o_ctrl_in_tdata;
  keep_t    o_ctrl_in_tkeep;
  logic     o_ctrl_in_tlast;
  logic     o_ctrl_in_tvalid;
  logic     i_ctrl_in_tready;
  word_t    o_data_in_tdata;
  keep_t    o_data_in_tkeep;
  logic     o_data_in_tlast;
  logic     o_data_in_tvalid;
  logic     i_data_in_tready;
  word_t    i_ctrl_out_tdata;
  keep_t    i_ctrl_out_tkeep;
  logic     i_ctrl_out_tlast;
  logic     i_ctrl_out_tvalid;
  logic     o_ctrl_out_tready;
  word_t    i_data_out_tdata;
  keep_t    i_data_out_tkeep;
  logic     i_data_out_tlast;
  logic     i_data_out_tvalid;
  logic     o_data_out_tready;

  // Queues 0 and 1 for ctrl_in and data_in, 2 and 3 for tx from ctrl and data
  beat_t       exp_q [4][$];
  string       port_names [3] = '{"rx", "ctrl_out", "data_out"};
  logic [31:0] lfsr;
  logic        hold_in;
  logic        tx_gaps;
  logic        stalled;
  int          stall_run;
  int          errors;
  int          checks;
  int          tests;
  int          err_mark;
  int          len;

  pcie_func_bridge uut (.*);

  always #50 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic ready_of(input int port);
    case (port)
      0:       return o_rx_tready;
      1:       return o_ctrl_out_tready;
      default: return o_data_out_tready;
    endcase
  endfunction

  function automatic int pending(input int lo, input int hi);
    int total;
    total = 0;
    for (int q = lo; q <= hi; q++) begin
      total += exp_q[q].size();
    end
    return total;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic compare_value(input string sig, input word_t got, input word_t want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("** Error: %s = 0x%h, expected 0x%h", sig, got, want);
    end
  endtask

  task automatic check_beat(input int idx, input string name, input word_t data,
                            input keep_t keep, input logic last);
    beat_t want;
    checks++;
    assert (exp_q[idx].size() > 0) else begin
      errors++;
      $display("unexpected beat on %s while no packet was outstanding", name);
    end
    if (exp_q[idx].size() > 0) begin
      want = exp_q[idx].pop_front();
      compare_value({name, "_tdata"}, data, want[`PB_DATA_W-1:0]);
      compare_value({name, "_tkeep"}, word_t'(keep), word_t'(want[`PB_DATA_W +: `PB_KEEP_W]));
      compare_value({name, "_tlast"}, word_t'(last), word_t'(want[LAST_BIT]));
    end
  endtask

  task automatic drive_beat(input int port, input beat_t b, input logic valid);
    case (port)
      0: begin
        i_rx_tdata  = b[`PB_DATA_W-1:0];
        i_rx_tkeep  = b[`PB_DATA_W +: `PB_KEEP_W];
        i_rx_tlast  = b[LAST_BIT];
        i_rx_tvalid = valid;
      end
      1: begin
        i_ctrl_out_tdata  = b[`PB_DATA_W-1:0];
        i_ctrl_out_tkeep  = b[`PB_DATA_W +: `PB_KEEP_W];
        i_ctrl_out_tlast  = b[LAST_BIT];
        i_ctrl_out_tvalid = valid;
      end
      default: begin
        i_data_out_tdata  = b[`PB_DATA_W-1:0];
        i_data_out_tkeep  = b[`PB_DATA_W +: `PB_KEEP_W];
        i_data_out_tlast  = b[LAST_BIT];
        i_data_out_tvalid = valid;
      end
    endcase
  endtask

  // Port 0 is rx, 1 is ctrl_out, 2 is data_out; toggle_at flips i_func_sel mid-packet
  task automatic send_packet(input int port, input int plen, input int toggle_at);
    beat_t pkt [$];
    int    waited;
    int    idx;
    for (int i = 0; i < plen; i++) begin
      pkt.push_back({(i == plen - 1), keep_t'(next_bits(`PB_KEEP_W)),
                     word_t'(next_bits(`PB_DATA_W))});
    end
    for (int i = 0; i < plen; i++) begin
      @(negedge clk);
      if (i == toggle_at) begin
        i_func_sel = (i_func_sel == FUNC_CONTROL) ? FUNC_DATA : FUNC_CONTROL;
      end
      drive_beat(port, pkt[i], 1'b1);
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
        if (waited > TIMEOUT) begin
          abort_on_timeout({"ready on ", port_names[port]});
        end
      end while (!ready_of(port));
      // The function taken on the first beat owns the whole packet
      if (i == 0) begin
        if (port == 0) begin
          idx = (i_func_sel == FUNC_CONTROL) ? 0 : 1;
        end else begin
          idx = port + 1;
        end
        foreach (pkt[k]) begin
          exp_q[idx].push_back(pkt[k]);
        end
      end
    end
    @(negedge clk);
    drive_beat(port, '0, 1'b0);
  endtask

  task automatic wait_empty(input int lo, input int hi, input string what);
    int waited;
    waited = 0;
    while (pending(lo, hi) != 0) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        abort_on_timeout(what);
      end
    end
  endtask

  // Gives up waiting after the timeout so the stall assertion can report it
  task automatic release_after_stall();
    int waited;
    waited = 0;
    while (!stalled && waited <= TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    repeat (20) @(negedge clk);
    @(posedge clk);
    hold_in = 1'b0;
  endtask

  task automatic drive_ready_gaps();
    logic [1:0] ctrl_bits;
    logic [1:0] data_bits;
    logic [1:0] tx_bits;
    forever begin
      // Gap bits drawn on the rising edge, readies driven on the falling edge
      @(posedge clk);
      ctrl_bits = 2'(next_bits(2));
      data_bits = 2'(next_bits(2));
      tx_bits   = 2'(next_bits(2));
      @(negedge clk);
      i_ctrl_in_tready = !hold_in && (ctrl_bits != 0);
      i_data_in_tready = !hold_in && (data_bits != 0);
      i_tx_tready      = !tx_gaps || (tx_bits != 0);
    end
  endtask

  task automatic watch_outputs();
    forever begin
      @(posedge clk);
      if (o_ctrl_in_tvalid && i_ctrl_in_tready) begin
        check_beat(0, "o_ctrl_in", o_ctrl_in_tdata, o_ctrl_in_tkeep, o_ctrl_in_tlast);
      end
      if (o_data_in_tvalid && i_data_in_tready) begin
        check_beat(1, "o_data_in", o_data_in_tdata, o_data_in_tkeep, o_data_in_tlast);
      end
      if (o_tx_tvalid && i_tx_tready) begin
        check_beat((i_func_sel == FUNC_CONTROL) ? 2 : 3, "o_tx",
                   o_tx_tdata, o_tx_tkeep, o_tx_tlast);
      end
      // A long run of refused rx beats means both ingress banks are full
      if (i_rx_tvalid && !o_rx_tready) begin
        stall_run++;
      end else begin
        stall_run = 0;
      end
      if (stall_run > 8) begin
        stalled = 1'b1;
      end
    end
  endtask

  task automatic check_idle_valids();
    compare_value("o_tx_tvalid", word_t'(o_tx_tvalid), '0);
    compare_value("o_ctrl_in_tvalid", word_t'(o_ctrl_in_tvalid), '0);
    compare_value("o_data_in_tvalid", word_t'(o_data_in_tvalid), '0);
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %s finished with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    lfsr       = SEED;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    err_mark   = 0;
    hold_in    = 1'b0;
    tx_gaps    = 1'b0;
    stalled    = 1'b0;
    stall_run  = 0;
    i_rst_n    = 1'b0;
    i_func_sel = FUNC_CONTROL;
    i_ctrl_in_tready = 1'b0;
    i_data_in_tready = 1'b0;
    i_tx_tready      = 1'b0;
    drive_beat(0, '0, 1'b0);
    drive_beat(1, '0, 1'b0);
    drive_beat(2, '0, 1'b0);
    fork
      drive_ready_gaps();
      watch_outputs();
    join_none

    // Reset held for two cycles
    repeat (2) begin
      @(negedge clk);
      check_idle_valids();
    end
    i_rst_n = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_idle_valids();
    end
    report_test("reset");

    @(negedge clk);
    i_func_sel = FUNC_CONTROL;
    repeat (6) send_packet(0, int'(next_bits(6)) + 1, -1);
    wait_empty(0, 3, "control ingress packets");
    repeat (4) @(negedge clk);
    report_test("control routing");

    @(negedge clk);
    i_func_sel = FUNC_DATA;
    repeat (6) send_packet(0, int'(next_bits(6)) + 1, -1);
    wait_empty(0, 3, "data ingress packets");
    repeat (4) @(negedge clk);
    report_test("data routing");

    repeat (4) begin
      len = int'(next_bits(5)) + 2;
      send_packet(0, len, len / 2);
    end
    wait_empty(0, 3, "packets with a mid-packet select change");
    repeat (4) @(negedge clk);
    report_test("packet lock");

    @(posedge clk);
    tx_gaps = 1'b1;
    repeat (3) begin
      @(negedge clk);
      i_func_sel = FUNC_CONTROL;
      repeat (2) send_packet(1, int'(next_bits(6)) + 1, -1);
      repeat (2) send_packet(2, int'(next_bits(6)) + 1, -1);
      wait_empty(2, 2, "control packets on tx");
      i_func_sel = FUNC_DATA;
      wait_empty(3, 3, "data packets on tx");
    end
    @(posedge clk);
    tx_gaps = 1'b0;
    repeat (4) @(negedge clk);
    report_test("egress");

    for (int f = 0; f < 2; f++) begin
      @(negedge clk);
      i_func_sel = (f == 0) ? FUNC_CONTROL : FUNC_DATA;
      @(posedge clk);
      hold_in = 1'b1;
      stalled = 1'b0;
      @(negedge clk);
      fork
        repeat (3) send_packet(0, int'(next_bits(6)) + 1, -1);
        release_after_stall();
      join
      wait_empty(0, 3, "back-pressured packets");
      checks++;
      assert (stalled) else begin
        errors++;
        $display("o_rx_tready never dropped while the ingress ready was held low");
      end
    end
    repeat (4) @(negedge clk);
    report_test("back-pressure");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
